/* echo_cfg.svh */
`ifndef ECHO_CFG_SVH
`define ECHO_CFG_SVH

`define ECHO_PTR_BITS    13           // Byte pointer width for 8192 samples in 2048 words
`define ECHO_BASE_ADDR   32'h33000000 // First word address of the delay line
`define ECHO_BUSY_CYCLES 3            // Busy stays high this long for every access
`define ECHO_MIN_GAP     16           // Sample strobes never come closer than this

// Delay in samples for each effect
`define ECHO_DLY_SLAP    300
`define ECHO_DLY_SHORT   1000
`define ECHO_DLY_LONG    4000
`define ECHO_DLY_DOUBLE  40

// Right shift applied to the delayed sample for each effect
`define ECHO_SHIFT_SLAP   1
`define ECHO_SHIFT_SHORT  1
`define ECHO_SHIFT_LONG   2
`define ECHO_SHIFT_DOUBLE 0

`endif

/* echoPkg.sv */
package echoPkg;

    // Effect selection as seen on the effect input pins
    typedef enum logic [2:0] {
        BYPASS    = 3'd0, // Dry signal only
        SLAPBACK  = 3'd1, // Short single repeat
        SHORTECHO = 3'd2, // Medium delay at half level
        LONGECHO  = 3'd3, // Long delay at quarter level
        DOUBLING  = 3'd4  // Very short delay at full level
    } effectCode; // Codes 5 to 7 fall back to the dry signal

    // One SRAM word holding four consecutive samples
    typedef union packed {
        logic [31:0]     word;  // Whole word as seen on the bus
        logic [3:0][7:0] bytes; // Byte 0 carries the oldest sample of the four
    } sramWord;

endpackage

/* effectDecoder.sv */
`timescale 1ns/10ps
`include "echo_cfg.svh"

module effectDecoder import echoPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      sampleValid, // One cycle per incoming sample
    input  logic [7:0]                sampleIn,    // Signed dry sample
    input  logic [2:0]                effect,      // Raw effect code from the outside
    output logic                      record,      // Store the captured sample
    output logic                      search,      // Fetch the delayed sample
    output logic                      modeChange,  // Effect differs from last cycle
    output logic                      bypass,      // Mixer passes the dry sample only
    output logic [`ECHO_PTR_BITS-1:0] offset,      // Delay in samples
    output logic [1:0]                shift,       // Attenuation of the delayed sample
    output logic [7:0]                dryOut       // Sample held for the controller and mixer
);

    effectCode effectReg;  // Effect code sampled every cycle
    effectCode effectPrev; // Its value one cycle earlier

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            effectReg  <= BYPASS; // Start as if the dry path was selected
            effectPrev <= BYPASS;
            record     <= 1'b0;
            search     <= 1'b0;
        end else begin
            effectReg  <= effectCode'(effect); // Codes 5 to 7 are kept and decoded below
            effectPrev <= effectReg;
            record     <= sampleValid; // First stage of the strobe sequencer
            search     <= record;      // Second stage follows one cycle later
        end
    end

    // Dry sample stays put until the next strobe
    always_ff @(posedge clk) begin
        if (sampleValid) begin
            dryOut <= sampleIn;
        end
    end

    assign modeChange = (effectReg != effectPrev); // Pulses once per change

    // Table lookup of delay and gain
    always_comb begin
        bypass = 1'b0;
        offset = '0;
        shift  = 2'd0;
        case (effectReg)
            SLAPBACK: begin
                offset = `ECHO_PTR_BITS'(`ECHO_DLY_SLAP);
                shift  = 2'(`ECHO_SHIFT_SLAP);
            end
            SHORTECHO: begin
                offset = `ECHO_PTR_BITS'(`ECHO_DLY_SHORT);
                shift  = 2'(`ECHO_SHIFT_SHORT);
            end
            LONGECHO: begin
                offset = `ECHO_PTR_BITS'(`ECHO_DLY_LONG);
                shift  = 2'(`ECHO_SHIFT_LONG);
            end
            DOUBLING: begin
                offset = `ECHO_PTR_BITS'(`ECHO_DLY_DOUBLE);
                shift  = 2'(`ECHO_SHIFT_DOUBLE);
            end
            default: begin
                bypass = 1'b1; // BYPASS and the unused codes 5 to 7
            end
        endcase
    end

endmodule

/* delayLineCtrl.sv */
`timescale 1ns/10ps
`include "echo_cfg.svh"

module delayLineCtrl import echoPkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      record,       // Store sampleIn at the next position
    input  logic                      search,       // Fetch the sample offset positions back
    input  logic                      modeChange,   // Restart cleaning
    input  logic [`ECHO_PTR_BITS-1:0] offset,       // Delay in samples
    input  logic [7:0]                sampleIn,     // Sample to be stored
    input  sramWord                   busRead,      // SRAM read data
    input  logic                      busy,         // SRAM access in progress
    output sramWord                   busWrite,     // SRAM write data
    output logic [31:0]               addressOut,   // SRAM word address
    output logic                      write,        // Write request level
    output logic                      read,         // Read request level
    output logic [7:0]                delayed,      // Delayed sample for the mixer
    output logic                      delayedValid  // One cycle when delayed is fresh
);

    localparam int wordBits = `ECHO_PTR_BITS - 2; // Word index width

    logic [`ECHO_PTR_BITS-1:0] pointer;     // Position of the most recent sample
    logic [`ECHO_PTR_BITS-1:0] nextPointer; // Position the next record will use
    logic [`ECHO_PTR_BITS-1:0] readPos;     // Target position while search is high
    logic [`ECHO_PTR_BITS-1:0] rdPos;       // Target position held for the lookup
    sramWord                   stage;       // Samples collected for the next word write
    sramWord                   nextStage;   // Staging word with the new sample merged in
    logic                      launchWrite; // The fourth sample of a word arrives
    logic                      lookup;      // Cycle after search
    logic                      readPend;    // Read waiting behind a write
    logic                      needRead;    // Miss that must go to the SRAM
    logic                      launchRead;  // Read request rises at this edge
    logic                      busyPrev;    // Busy one cycle ago
    logic                      busDone;     // Busy has just fallen
    logic                      cacheValid;  // Cached word holds real data
    logic [wordBits-1:0]       cacheTag;    // Word index of the cached word
    sramWord                   cacheWord;   // Last word read from the SRAM
    logic                      cacheHit;    // Lookup target lies in the cached word
    logic                      cleaning;    // Old samples are still in the window
    logic [`ECHO_PTR_BITS:0]   cleanCount;  // Records seen since the last effect change
    logic                      dirty;       // Delayed sample predates the effect change

    always_comb begin
        nextPointer = pointer + 1'b1;
        nextStage = stage;
        nextStage.bytes[nextPointer[1:0]] = sampleIn; // Slot follows the low pointer bits
    end

    assign readPos     = pointer - offset; // Pointer already includes the current sample
    assign launchWrite = record && (nextPointer[1:0] == 2'd3);
    assign busDone     = busyPrev && !busy;
    assign cacheHit    = cacheValid && (cacheTag == rdPos[`ECHO_PTR_BITS-1:2]);
    assign dirty       = cleaning && (cleanCount <= {1'b0, offset}); // Current sample counted
    assign needRead    = (lookup && !dirty && !cacheHit) || readPend;
    assign launchRead  = needRead && (!write || busDone); // Write finishes first

    // Pointer, strobes and request levels
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pointer      <= '0;
            busyPrev     <= 1'b0;
            lookup       <= 1'b0;
            readPend     <= 1'b0;
            write        <= 1'b0;
            read         <= 1'b0;
            delayedValid <= 1'b0;
        end else begin
            busyPrev <= busy;
            lookup   <= search;
            readPend <= needRead && !launchRead; // Hold the miss until the bus is free
            if (record) begin
                pointer <= nextPointer; // Advances in the record cycle itself
            end
            if (launchWrite) begin
                write <= 1'b1;
            end else if (write && busDone) begin
                write <= 1'b0; // Drop with the fall of busy
            end
            if (launchRead) begin
                read <= 1'b1;
            end else if (read && busDone) begin
                read <= 1'b0;
            end
            delayedValid <= (lookup && (dirty || cacheHit)) || (read && busDone);
        end
    end

    // Cleaning state after an effect change
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cleaning   <= 1'b0; // Memory is treated as clean out of reset
            cleanCount <= '0;
        end else if (modeChange) begin
            cleaning   <= 1'b1;
            cleanCount <= {{`ECHO_PTR_BITS{1'b0}}, record}; // A record in the same cycle already counts
        end else if (cleaning) begin
            if (!dirty) begin
                cleaning <= 1'b0; // A full delay of new samples is in place
            end else if (record) begin
                cleanCount <= cleanCount + 1'b1;
            end
        end
    end

    // Cache tag and valid flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cacheValid <= 1'b0;
            cacheTag   <= '0;
        end else if (modeChange) begin
            cacheValid <= 1'b0; // New delay window so the old word is dropped
        end else if (read && busDone) begin
            cacheValid <= 1'b1;
            cacheTag   <= rdPos[`ECHO_PTR_BITS-1:2];
        end
    end

    // Data path registers
    always_ff @(posedge clk) begin
        if (record) begin
            stage <= nextStage;
        end
        if (search) begin
            rdPos <= readPos;
        end
        if (launchWrite) begin
            busWrite   <= nextStage;
            addressOut <= `ECHO_BASE_ADDR + 32'(nextPointer[`ECHO_PTR_BITS-1:2]);
        end else if (launchRead) begin
            addressOut <= `ECHO_BASE_ADDR + 32'(rdPos[`ECHO_PTR_BITS-1:2]);
        end
        if (read && busDone) begin
            cacheWord.word <= busRead.word;
        end else if (launchWrite && cacheValid
                     && (cacheTag == nextPointer[`ECHO_PTR_BITS-1:2])) begin
            cacheWord.word <= nextStage.word; // Keep the cached copy in step with memory
        end
        if (lookup && dirty) begin
            delayed <= 8'd0; // Window still reaches behind the effect change
        end else if (lookup && cacheHit) begin
            delayed <= cacheWord.bytes[rdPos[1:0]];
        end else if (read && busDone) begin
            delayed <= busRead.bytes[rdPos[1:0]];
        end
    end

endmodule

/* sampleSram.sv */
`timescale 1ns/10ps
`include "echo_cfg.svh"

module sampleSram import echoPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addressOut, // Word address including the base
    input  sramWord     busWrite,   // Data for a write access
    input  logic        write,      // Write request level
    input  logic        read,       // Read request level
    output sramWord     busRead,    // Valid on the cycle busy falls
    output logic        busy        // Access in progress
);

    localparam int wordBits = `ECHO_PTR_BITS - 2;
    localparam int cntBits  = $clog2(`ECHO_BUSY_CYCLES + 1);

    sramWord             mem [0:(1 << wordBits) - 1]; // Delay line storage
    logic [cntBits-1:0]  busyCount;  // Busy cycles left after this one
    logic                finish;     // Cycle in which busy has just fallen
    logic                start;      // An access is accepted this cycle
    logic                opWrite;    // Latched kind of the running access
    logic [wordBits-1:0] index;      // Word index from the bus address
    logic [wordBits-1:0] opIndex;    // Latched word index
    sramWord             dataLatch;  // Latched write data

    assign index = wordBits'(addressOut - `ECHO_BASE_ADDR);
    assign start = (write || read) && !busy && !finish; // Requester drops its level on finish

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            busyCount <= '0;
            finish    <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy      <= 1'b1; // Busy rises the cycle after the request
                busyCount <= cntBits'(`ECHO_BUSY_CYCLES - 1);
            end else if (busy) begin
                if (busyCount == '0) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end else begin
                    busyCount <= busyCount - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            opWrite   <= write;
            opIndex   <= index;
            dataLatch <= busWrite;
        end
        if (busy && busyCount == '0) begin
            if (opWrite) begin
                mem[opIndex] <= dataLatch; // Whole word stored at the end of the busy period
            end else begin
                busRead <= mem[opIndex];
            end
        end
    end

endmodule

/* echoMixer.sv */
`timescale 1ns/10ps

module echoMixer (
    input  logic       clk,
    input  logic       rst,
    input  logic       delayedValid, // Delayed sample is ready
    input  logic [7:0] delayed,      // Signed delayed sample
    input  logic [7:0] dryOut,       // Signed dry sample
    input  logic [1:0] shift,        // Arithmetic right shift of the delayed sample
    input  logic       bypass,       // Pass the dry sample unchanged
    output logic [7:0] mixOut,       // Signed mixed sample
    output logic       mixValid      // One cycle per output sample
);

    logic signed [7:0] dry;     // Signed view of the dry sample
    logic signed [7:0] scaled;  // Attenuated delayed sample
    logic signed [8:0] sum;     // One extra bit catches overflow
    logic        [7:0] satSum;  // Sum clamped to the 8-bit range
    logic        [7:0] mixNext; // Value loaded on delayedValid

    always_comb begin
        dry    = $signed(dryOut);
        scaled = $signed(delayed) >>> shift; // Sign bit is replicated
        sum    = {dry[7], dry} + {scaled[7], scaled};
        if (sum[8] != sum[7]) begin
            // The two top bits disagree only when the true sum left the range
            satSum = sum[8] ? 8'h80 : 8'h7f;
        end else begin
            satSum = sum[7:0];
        end
        mixNext = bypass ? dryOut : satSum;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mixValid <= 1'b0;
        end else begin
            mixValid <= delayedValid; // Exactly one cycle behind
        end
    end

    always_ff @(posedge clk) begin
        if (delayedValid) begin
            mixOut <= mixNext;
        end
    end

endmodule

/* echoUnit.sv */
`timescale 1ns/10ps

module echoUnit import echoPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       sampleValid, // One strobe per incoming sample
    input  logic [7:0] sampleIn,    // Signed input sample
    input  logic [2:0] effect,      // Effect selection
    output logic [7:0] mixOut,      // Signed output sample
    output logic       mixValid     // One strobe per output sample
);

    logic        record;       // Decoder asks for a store
    logic        search;       // Decoder asks for a fetch
    logic        modeChange;   // Effect has just changed
    logic        bypass;       // Dry path only
    logic [12:0] offset;       // Delay in samples
    logic [1:0]  shift;        // Gain as a right shift
    logic [7:0]  dryOut;       // Captured dry sample
    sramWord     busWrite;     // Controller to SRAM data
    sramWord     busRead;      // SRAM to controller data
    logic [31:0] addressOut;   // SRAM word address
    logic        write;        // SRAM write level
    logic        read;         // SRAM read level
    logic        busy;         // SRAM busy
    logic [7:0]  delayed;      // Delayed sample
    logic        delayedValid; // Delayed sample strobe

    effectDecoder decoder (
        .clk, .rst, .sampleValid, .sampleIn, .effect,
        .record, .search, .modeChange, .bypass, .offset, .shift, .dryOut
    );

    // The controller stores the captured copy so the input may change after the strobe
    delayLineCtrl ctrl (
        .clk, .rst, .record, .search, .modeChange, .offset,
        .sampleIn(dryOut), .busRead, .busy,
        .busWrite, .addressOut, .write, .read, .delayed, .delayedValid
    );

    sampleSram sram (
        .clk, .rst, .addressOut, .busWrite, .write, .read, .busRead, .busy
    );

    echoMixer mixer (
        .clk, .rst, .delayedValid, .delayed, .dryOut, .shift, .bypass,
        .mixOut, .mixValid
    );

endmodule

/* echoUnit_assertions.sv */
`timescale 1ns/10ps
`include "echo_cfg.svh"

module echoUnit_assertions (
    input logic clk,
    input logic rst,
    input logic record,       // Store strobe from the decoder
    input logic search,       // Fetch strobe from the decoder
    input logic write,        // SRAM write level
    input logic read,         // SRAM read level
    input logic busy,         // SRAM busy
    input logic delayedValid  // Delayed sample strobe
);

    logic [7:0] sinceRecord; // Cycles since the last record, saturating
    logic [7:0] searchAge;   // Cycles since the search that is still open
    logic       searchOpen;  // A search waits for its delayed sample

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sinceRecord <= 8'(`ECHO_MIN_GAP); // First record after reset is always legal
            searchAge   <= 8'd0;
            searchOpen  <= 1'b0;
        end else begin
            if (record) begin
                sinceRecord <= 8'd1;
            end else if (sinceRecord != 8'hff) begin
                sinceRecord <= sinceRecord + 8'd1;
            end
            if (search) begin
                searchOpen <= 1'b1;
                searchAge  <= 8'd1;
            end else if (delayedValid) begin
                searchOpen <= 1'b0; // Answer delivered
            end else if (searchOpen) begin
                searchAge <= searchAge + 8'd1;
            end
        end
    end

    // Only one SRAM request level at a time
    assert property (@(posedge clk) disable iff (rst) !(write && read))
        else $error("write and read requests overlap");

    // A level drops one edge after busy fell, so busy was high two samples back
    assert property (@(posedge clk) disable iff (rst)
        $fell(write) |-> (!$past(busy) && $past(busy, 2)))
        else $error("write request dropped before busy fell");

    assert property (@(posedge clk) disable iff (rst)
        $fell(read) |-> (!$past(busy) && $past(busy, 2)))
        else $error("read request dropped before busy fell");

    assert property (@(posedge clk) disable iff (rst) searchOpen |-> searchAge <= `ECHO_MIN_GAP)
        else $error("delayed sample took longer than the strobe spacing");

    // Every search is answered before the next one arrives
    assert property (@(posedge clk) disable iff (rst) search |-> !searchOpen)
        else $error("search issued before the previous delayed sample arrived");

    assert property (@(posedge clk) disable iff (rst) delayedValid |-> searchOpen)
        else $error("delayed sample strobe without a search");

    assert property (@(posedge clk) disable iff (rst) record |-> sinceRecord >= `ECHO_MIN_GAP)
        else $error("record strobes closer than the minimum spacing");

endmodule

bind delayLineCtrl echoUnit_assertions protocolChecks (
    .clk(clk), .rst(rst), .record(record), .search(search), .write(write), .read(read),
    .busy(busy), .delayedValid(delayedValid)
);

/* echoUnit_tb.sv */
`timescale 1ns/10ps
`include "echo_cfg.svh"

module echoUnit_tb import echoPkg::*; ();

    localparam int bypassCount  = 40;   // Dry samples right after reset
    localparam int unusedCount  = 10;   // Samples for each of the codes 5 to 7
    localparam int shortCount   = 1300; // Cleaning window plus 300 echoes
    localparam int doubleCount  = 500;  // Delay of 40 so many lookups hit the cached word
    localparam int slapCount    = 400;
    localparam int longCount    = 4500; // 4000 silent lookups and then the quarter level echo
    localparam int wrapCount    = 1500; // Pushes the pointer past 8192 so addresses wrap
    localparam int totalSamples = bypassCount + 3 * unusedCount + shortCount + doubleCount
                                  + slapCount + longCount + wrapCount;
    localparam int cycleLimit   = totalSamples * `ECHO_MIN_GAP + 200;

    logic        clk;
    logic        rst;
    logic        sampleValid;
    logic [7:0]  sampleIn;
    logic [2:0]  effect;
    logic [7:0]  mixOut;
    logic        mixValid;

    logic [31:0] lfsrState;                 // Galois LFSR that feeds the samples
    logic [7:0]  history [0:totalSamples];  // Every sample sent, indexed from 1
    int          sentCount;                 // Samples sent so far
    int          sinceChange;               // Samples since the effect code last changed
    logic [2:0]  lastCode;                  // Effect code of the previous sample
    logic [7:0]  expectedQ [$];             // Model outputs still waiting for mixValid
    int          indexQ [$];                // Sample number of each waiting output
    logic [7:0]  want;
    int          wantIndex;
    int          valueErrors    = 0;
    int          protocolErrors = 0;
    int          missingErrors  = 0;
    int          checkedCount   = 0;
    int          cycleCount     = 0;

    echoUnit uut (
        .clk, .rst, .sampleValid, .sampleIn, .effect, .mixOut, .mixValid
    );

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 ns period

    // Right shift by one bit per step with the taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    function automatic logic [7:0] randomByte();
        logic [7:0] value;
        value = 8'h00;
        for (int i = 0; i < 8; i++) begin
            value     = {value[6:0], lfsrState[0]}; // One LFSR step per bit taken
            lfsrState = lfsrNext(lfsrState);
        end
        return value;
    endfunction

    // Delay and gain of each effect code where codes 5 to 7 pass the dry sample
    function automatic void decodeEffect(input logic [2:0] code, output logic dry,
                                         output int delay, output int sh);
        dry   = 1'b0;
        delay = 0;
        sh    = 0;
        case (code)
            SLAPBACK: begin
                delay = `ECHO_DLY_SLAP;
                sh    = `ECHO_SHIFT_SLAP;
            end
            SHORTECHO: begin
                delay = `ECHO_DLY_SHORT;
                sh    = `ECHO_SHIFT_SHORT;
            end
            LONGECHO: begin
                delay = `ECHO_DLY_LONG;
                sh    = `ECHO_SHIFT_LONG;
            end
            DOUBLING: begin
                delay = `ECHO_DLY_DOUBLE;
                sh    = `ECHO_SHIFT_DOUBLE;
            end
            default: dry = 1'b1;
        endcase
    endfunction

    // Signed sum clamped to the 8-bit range
    function automatic logic [7:0] mixModel(input logic [7:0] dry, input logic [7:0] echoByte,
                                            input int sh);
        int total;
        total = int'($signed(dry)) + (int'($signed(echoByte)) >>> sh);
        if (total > 127) begin
            total = 127;
        end else if (total < -128) begin
            total = -128;
        end
        return 8'(total);
    endfunction

    task automatic sendSample(input logic [2:0] code);
        logic [7:0] value;
        logic [7:0] echoByte;
        logic       dry;
        int         delay;
        int         sh;
        if (expectedQ.size() != 0) begin
            $display("No output arrived for sample %0d", indexQ[0]);
            missingErrors++;
            void'(expectedQ.pop_front());
            void'(indexQ.pop_front());
        end
        value = randomByte();
        sentCount++;
        history[sentCount] = value;
        if (code != lastCode) begin
            sinceChange = 0; // Delay line counts as empty again after a change
        end
        lastCode = code;
        sinceChange++;
        decodeEffect(code, dry, delay, sh);
        echoByte = (sinceChange > delay) ? history[sentCount - delay] : 8'h00;
        expectedQ.push_back(dry ? value : mixModel(value, echoByte, sh));
        indexQ.push_back(sentCount);
        @(posedge clk);
        sampleValid <= 1'b1;
        sampleIn    <= value;
        effect      <= code; // A new code takes effect with this sample
        @(posedge clk);
        sampleValid <= 1'b0;
        repeat (`ECHO_MIN_GAP - 2) @(posedge clk); // Strobes exactly ECHO_MIN_GAP apart
    endtask

    task automatic runPhase(input logic [2:0] code, input int count);
        for (int i = 0; i < count; i++) begin
            sendSample(code);
        end
    endtask

    // Outputs are compared half a cycle after the edge that set them
    always @(negedge clk) begin
        if (rst) begin
            assert (!mixValid) else begin
                $display("mixValid went high while reset was asserted");
                protocolErrors++;
            end
        end else if (mixValid) begin
            if (expectedQ.size() == 0) begin
                $display("mixValid pulsed with no sample outstanding");
                protocolErrors++;
            end else begin
                want      = expectedQ.pop_front();
                wantIndex = indexQ.pop_front();
                checkedCount++;
                assert (mixOut == want) else begin
                    $display("FAILED mixOut: got %h expected %h at sample %0d",
                             mixOut, want, wantIndex);
                    valueErrors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("Timeout after %0d cycles with %0d outputs still outstanding",
                     cycleLimit, expectedQ.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        sampleValid = 1'b0;
        sampleIn    = 8'h00;
        effect      = BYPASS;
        lfsrState   = 32'h97ff;
        sentCount   = 0;
        sinceChange = 0;
        lastCode    = BYPASS; // Decoder leaves reset with BYPASS selected
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        runPhase(BYPASS, bypassCount);
        runPhase(3'd5, unusedCount);
        runPhase(3'd6, unusedCount);
        runPhase(3'd7, unusedCount);
        runPhase(SHORTECHO, shortCount);
        runPhase(DOUBLING, doubleCount);
        runPhase(SLAPBACK, slapCount);
        runPhase(LONGECHO, longCount);
        runPhase(SHORTECHO, wrapCount);
        while (expectedQ.size() != 0) @(posedge clk);
        repeat (`ECHO_MIN_GAP) @(posedge clk); // Room for a stray extra strobe
        $display("Checked %0d of %0d outputs: %0d value errors, %0d protocol errors, %0d missing",
                 checkedCount, sentCount, valueErrors, protocolErrors, missingErrors);
        if (valueErrors + protocolErrors + missingErrors == 0 && checkedCount == sentCount) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* echoUnit.f */
+incdir+.
echoPkg.sv
effectDecoder.sv
delayLineCtrl.sv
sampleSram.sv
echoMixer.sv
echoUnit.sv
echoUnit_assertions.sv
echoUnit_tb.sv

/* Makefile */
TOP = echoUnit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f echoUnit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f echoUnit.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
